// ==== ahb_lite_matrix.f ====
src/ahb_lite_pkg.sv
src/ahb_lite_decoder.sv
src/ahb_ram_slave.sv
src/ahb_gpio_slave.sv
src/ahb_lite_response_mux.sv
src/ahb_lite_matrix.sv
bench/ahb_lite_matrix_assert.sv
bench/tb_ahb_lite_matrix.sv

// ==== Makefile ====
# Verilator build and run for the AHB-Lite matrix testbench
# Any variable can be overridden, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= tb_ahb_lite_matrix
FILELIST  ?= ahb_lite_matrix.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The log decides the result, the simulator exit status does not
run: $(SIM_BIN) bench/matrix_tests.txt
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx 'test passed' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/matrix_tests.txt ====
# name op(r/w) address size(0 byte, 1 half, 2 word) wdata-or-expected-rdata hresp switches
# Numbers in hex; reads compare the whole 32-bit word
ram_w0      w 00000000 2 11223344 0 0000
ram_w1      w 00000004 2 a5a5f00f 0 0000
ram_w2      w 000003fc 2 deadbeef 0 0000
ram_r0      r 00000000 2 11223344 0 0000
ram_r2      r 000003fc 2 deadbeef 0 0000
ram_r1      r 00000004 2 a5a5f00f 0 0000
lane_base0  w 00000010 2 00000000 0 0000
lane_b2     w 00000012 0 00ab0000 0 0000
lane_b3     w 00000013 0 cd000000 0 0000
lane_h0     w 00000010 1 00001234 0 0000
lane_r0     r 00000010 2 cdab1234 0 0000
lane_b1     w 00000011 0 99887766 0 0000
lane_r1     r 00000010 2 cdab7734 0 0000
lane_base1  w 00000014 2 ffffffff 0 0000
lane_h2     w 00000016 1 56780000 0 0000
lane_b4     w 00000014 0 000000aa 0 0000
lane_r2     r 00000014 2 5678ffaa 0 0000
led_w       w 1f800004 2 abcd5a5a 0 0000
led_r       r 1f800004 2 00005a5a 0 0000
hex_w       w 1f800008 2 12345678 0 0000
hex_r       r 1f800008 2 12345678 0 0000
sw_w        w 1f800000 2 ffffffff 0 0000
led_r_sw    r 1f800004 2 00005a5a 0 0000
sw_r0       r 1f800000 2 0000c3a5 0 c3a5
sw_r1       r 1f800000 2 00001234 0 1234
bad_r       r 40000000 2 00000000 1 1234
bad_w       w 40000000 2 ffffffff 1 1234
bad_ram_w   w 00010000 2 ffffffff 1 1234
bad_gpio_w  w 1f801004 2 0000ffff 1 1234
after_ram   r 00000000 2 11223344 0 1234
after_led   r 1f800004 2 00005a5a 0 1234
after_hex   r 1f800008 2 12345678 0 1234

// ==== bench/tb_ahb_lite_matrix.sv ====
`timescale 1ns/1ps

module tb_ahb_lite_matrix;

    import ahb_lite_pkg::*;

    localparam int     READY_LIMIT = 16;               // Longest stall of one phase
    localparam int     RAM_WAITS   = 1;                // Matrix default wait states
    localparam haddr_t RAND_BASE   = 32'h0000_0200;    // Clear of the file addresses
    localparam int     RAND_WORDS  = 16;

    logic                  HCLK;
    logic                  HRESETn;
    haddr_t                HADDR;
    htrans_t               HTRANS;
    hsize_t                HSIZE;
    logic                  HWRITE;
    hdata_t                HWDATA;
    hdata_t                HRDATA;
    logic                  HREADY;
    logic                  HRESP;
    logic [N_SWITCHES-1:0] switches;
    logic [N_LEDS-1:0]     leds;
    logic [HEX_WIDTH-1:0]  hex;

    logic [7:0]            ram_model [4096];    // Byte image of the RAM
    logic [N_LEDS-1:0]     led_model;
    logic [HEX_WIDTH-1:0]  hex_model;
    integer                seed;
    int                    last_wait;           // Low cycles seen by the last wait

    ahb_lite_matrix u_dut (
        .HCLK     ( HCLK     ),
        .HRESETn  ( HRESETn  ),
        .HADDR    ( HADDR    ),
        .HTRANS   ( HTRANS   ),
        .HSIZE    ( HSIZE    ),
        .HWRITE   ( HWRITE   ),
        .HWDATA   ( HWDATA   ),
        .HRDATA   ( HRDATA   ),
        .HREADY   ( HREADY   ),
        .HRESP    ( HRESP    ),
        .switches ( switches ),
        .leds     ( leds     ),
        .hex      ( hex      )
    );

    initial begin
        HCLK = 1'b0;
        forever #20 HCLK = ~HCLK;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %s expected %h actual %h", name, expected, actual);
            $display("test failed");
            $fatal(1, "Check failed in %s", name);
        end
    endtask

    // Returns in a cycle where HREADY is high, sampled mid-cycle
    task automatic wait_ready(input string name);
        int cycles;
        cycles = 0;
        @(negedge HCLK);
        while (HREADY !== 1'b1) begin
            cycles++;
            if (cycles > READY_LIMIT) begin
                $display("Timeout: HREADY stayed low during %s", name);
                $display("test failed");
                $fatal(1, "Bus timeout");
            end
            @(negedge HCLK);
        end
        last_wait = cycles;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge HCLK);
        #1;
    endtask

    // ------------------------------------------------------------------------
    // Master model, called 1 ns after a rising edge
    // ------------------------------------------------------------------------
    task automatic bus_transfer(input string name, input logic write, input haddr_t addr,
                                input hsize_t size, input hdata_t wdata,
                                output hdata_t rdata, output logic resp);
        HADDR  = addr;
        HTRANS = HTRANS_NONSEQ;
        HSIZE  = size;
        HWRITE = write;
        wait_ready(name);                   // Address phase
        idle_cycles(1);
        HTRANS = HTRANS_IDLE;
        HWDATA = write ? wdata : '0;
        wait_ready(name);                   // Data phase
        rdata = HRDATA;
        resp  = HRESP;
        check_value({name, " data cycles"}, data_phase_cycles(addr), 32'(last_wait + 1));
        idle_cycles(1);
    endtask

    // Second address phase overlaps the first data phase
    task automatic read_pair(input string name, input haddr_t addr_a, input haddr_t addr_b,
                             output hdata_t rdata_a, output hdata_t rdata_b);
        HADDR  = addr_a;
        HTRANS = HTRANS_NONSEQ;
        HSIZE  = SIZE_WORD;
        HWRITE = 1'b0;
        wait_ready(name);
        idle_cycles(1);
        HADDR = addr_b;
        wait_ready(name);
        rdata_a = HRDATA;
        check_value({name, " first cycles"}, data_phase_cycles(addr_a), 32'(last_wait + 1));
        idle_cycles(1);
        HTRANS = HTRANS_IDLE;
        wait_ready(name);
        rdata_b = HRDATA;
        check_value({name, " second cycles"}, data_phase_cycles(addr_b),
                    32'(last_wait + 1));
        idle_cycles(1);
    endtask

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    function automatic logic [3:0] lane_mask(input logic [1:0] ofs, input hsize_t size);
        int         nbytes;
        int         first;
        logic [3:0] mask;
        nbytes = 1 << size;
        first  = int'(ofs) & ~(nbytes - 1);     // Aligned to the transfer size
        mask   = '0;
        for (int i = 0; i < 4; i++) begin
            if (i >= first && i < first + nbytes) begin
                mask[i] = 1'b1;
            end
        end
        return mask;
    endfunction

    function automatic void model_write(input haddr_t addr, input hsize_t size,
                                        input hdata_t data);
        logic [3:0] mask;
        mask = lane_mask(addr[1:0], size);
        if (addr[31:16] == RAM_MATCH) begin
            for (int i = 0; i < 4; i++) begin
                if (mask[i]) begin
                    ram_model[{addr[11:2], 2'(i)}] = data[8*i +: 8];
                end
            end
        end else if (addr[31:12] == GPIO_MATCH) begin
            if (addr[7:0] == GPIO_LED_OFS) begin
                led_model = data[N_LEDS-1:0];
            end else if (addr[7:0] == GPIO_HEX_OFS) begin
                hex_model = data[HEX_WIDTH-1:0];
            end
        end
    endfunction

    function automatic hdata_t model_word(input haddr_t addr);
        return {ram_model[{addr[11:2], 2'd3}], ram_model[{addr[11:2], 2'd2}],
                ram_model[{addr[11:2], 2'd1}], ram_model[{addr[11:2], 2'd0}]};
    endfunction

    // Data phase length of an active transfer, by the slave that owns it
    function automatic logic [31:0] data_phase_cycles(input haddr_t addr);
        if (addr[31:16] == RAM_MATCH) begin
            return 32'(1 + RAM_WAITS);
        end else if (addr[31:12] == GPIO_MATCH) begin
            return 32'd1;
        end
        return 32'd2;                       // ERROR takes two cycles
    endfunction

    // ------------------------------------------------------------------------
    // Directed transfers from the data file
    // ------------------------------------------------------------------------
    task automatic run_file_tests();
        int          fd;
        int          count;
        int          n_lines;
        string       line;
        string       name;
        string       op;
        haddr_t      addr;
        logic [31:0] size_v;
        logic [31:0] resp_v;
        logic [31:0] sw_v;
        hdata_t      data;
        hdata_t      rdata;
        logic        resp;
        n_lines = 0;
        fd = $fopen("bench/matrix_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the test file bench/matrix_tests.txt");
            $display("test failed");
            $fatal(1, "Missing test file");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;                   // Blank or column description
            end
            count = $sscanf(line, "%s %s %h %h %h %h %h", name, op, addr, size_v, data,
                            resp_v, sw_v);
            if (count != 7 || (op != "r" && op != "w")) begin
                $display("Malformed line in the test file: %s", line);
                $display("test failed");
                $fatal(1, "Bad test file");
            end
            n_lines++;
            switches = sw_v[N_SWITCHES-1:0];
            idle_cycles(3);                 // Switches pass the synchroniser first
            bus_transfer(name, op == "w", addr, hsize_t'(size_v), data, rdata, resp);
            check_value({name, " hresp"}, resp_v, 32'(resp));
            if (op == "r") begin
                check_value(name, data, rdata);
                if (resp_v == 0 && addr[31:16] == RAM_MATCH) begin
                    check_value({name, " model"}, model_word(addr), rdata);
                end
            end else begin
                model_write(addr, hsize_t'(size_v), data);
            end
            check_value({name, " leds"}, 32'(led_model), 32'(leds));
            check_value({name, " hex"}, hex_model, hex);
        end
        $fclose(fd);
        if (n_lines == 0) begin
            $display("The test file holds no transfers");
            $display("test failed");
            $fatal(1, "Empty test file");
        end
    endtask

    // ------------------------------------------------------------------------
    // Random RAM traffic
    // ------------------------------------------------------------------------
    task automatic run_random_traffic();
        haddr_t     addr;
        haddr_t     raddr;
        hsize_t     size;
        logic [1:0] lane;
        int         widx;
        hdata_t     data;
        hdata_t     rdata;
        hdata_t     rdata_b;
        logic       resp;
        for (int i = 0; i < RAND_WORDS; i++) begin
            addr = RAND_BASE + haddr_t'(4 * i);
            data = (addr * 32'h9E37_79B9) ^ 32'h0F1E_2D3C;     // Address-dependent fill
            bus_transfer("rand_fill", 1'b1, addr, SIZE_WORD, data, rdata, resp);
            model_write(addr, SIZE_WORD, data);
        end
        for (int n = 0; n < 64; n++) begin
            size = hsize_t'($unsigned($random(seed)) % 3);
            widx = int'($unsigned($random(seed)) % RAND_WORDS);
            lane = 2'($random(seed));
            if (size != SIZE_BYTE) begin
                lane[0] = 1'b0;
            end
            if (size == SIZE_WORD) begin
                lane = 2'd0;
            end
            addr = RAND_BASE + haddr_t'(4 * widx) + haddr_t'(lane);
            data = $random(seed);
            bus_transfer($sformatf("rand_write_%0d", n), 1'b1, addr, size, data, rdata, resp);
            check_value($sformatf("rand_write_%0d hresp", n), 32'd0, 32'(resp));
            model_write(addr, size, data);
            raddr = RAND_BASE + haddr_t'(4 * ($unsigned($random(seed)) % RAND_WORDS));
            bus_transfer($sformatf("rand_read_%0d", n), 1'b0, raddr, SIZE_WORD, '0, rdata, resp);
            check_value($sformatf("rand_read_%0d", n), model_word(raddr), rdata);
            if (n % 8 == 7) begin
                raddr = RAND_BASE + haddr_t'(4 * (n % (RAND_WORDS - 1)));
                read_pair($sformatf("rand_pair_%0d", n), raddr, raddr + 4, rdata, rdata_b);
                check_value($sformatf("rand_pair_%0d first", n), model_word(raddr), rdata);
                check_value($sformatf("rand_pair_%0d second", n), model_word(raddr + 4),
                            rdata_b);
            end
        end
    endtask

    initial begin
        seed      = 32'h328d6f88;
        HRESETn   = 1'b0;
        HADDR     = '0;
        HTRANS    = HTRANS_IDLE;
        HSIZE     = SIZE_WORD;
        HWRITE    = 1'b0;
        HWDATA    = '0;
        switches  = '0;
        led_model = '0;
        hex_model = '0;
        last_wait = 0;
        repeat (2) @(posedge HCLK);
        #1;
        HRESETn = 1'b1;
        run_file_tests();
        run_random_traffic();
        idle_cycles(2);
        $display("test passed");
        $finish;
    end

endmodule

// ==== bench/ahb_lite_matrix_assert.sv ====
`timescale 1ns/1ps

module ahb_lite_matrix_assert (
    input logic                 HCLK,
    input logic                 HRESETn,
    input logic                 HREADY,
    input logic                 HRESP,
    input ahb_lite_pkg::hdata_t HRDATA
);

    // ------------------------------------------------------------------------
    // Response protocol
    // ------------------------------------------------------------------------
    property error_two_cycle;   // ERROR ends with HREADY and HRESP high
        @(posedge HCLK) disable iff (!HRESETn)
            (HRESP && !HREADY) |=> (HRESP && HREADY);
    endproperty

    property response_known;
        @(posedge HCLK) disable iff (!HRESETn)
            !$isunknown({HRDATA, HRESP, HREADY});
    endproperty

    property ready_after_reset;
        @(posedge HCLK) $rose(HRESETn) |-> HREADY;
    endproperty

    assert property (error_two_cycle)
        else $error("ERROR response was not followed by HREADY and HRESP high");
    assert property (response_known)
        else $error("HRDATA, HRESP or HREADY is unknown after reset");
    assert property (ready_after_reset)
        else $error("HREADY low in the first cycle after reset");

endmodule

bind ahb_lite_matrix ahb_lite_matrix_assert u_protocol_assert (
    .HCLK    ( HCLK    ),
    .HRESETn ( HRESETn ),
    .HREADY  ( HREADY  ),
    .HRESP   ( HRESP   ),
    .HRDATA  ( HRDATA  )
);

// ==== src/ahb_lite_matrix.sv ====
`timescale 1ns/1ps

module ahb_lite_matrix #(
    parameter int RAM_ADDR_WIDTH  = 10,
    parameter int RAM_WAIT_STATES = 1     // 0 to 3
) (
    input  logic                                  HCLK,
    input  logic                                  HRESETn,
    input  ahb_lite_pkg::haddr_t                  HADDR,
    input  ahb_lite_pkg::htrans_t                 HTRANS,
    input  ahb_lite_pkg::hsize_t                  HSIZE,
    input  logic                                  HWRITE,
    input  ahb_lite_pkg::hdata_t                  HWDATA,
    output ahb_lite_pkg::hdata_t                  HRDATA,
    output logic                                  HREADY,
    output logic                                  HRESP,
    input  logic [ahb_lite_pkg::N_SWITCHES-1:0]   switches,
    output logic [ahb_lite_pkg::N_LEDS-1:0]       leds,
    output logic [ahb_lite_pkg::HEX_WIDTH-1:0]    hex
);

    import ahb_lite_pkg::*;

    hsel_t  hsel;           // Address phase select
    hsel_t  data_sel;       // Data phase owner
    logic   ram_hreadyout;
    hdata_t ram_hrdata;
    logic   ram_hresp;
    logic   gpio_hreadyout;
    hdata_t gpio_hrdata;
    logic   gpio_hresp;

    // ------------------------------------------------------------------------
    // Input side
    // ------------------------------------------------------------------------
    ahb_lite_decoder u_decoder (
        .HCLK     ( HCLK     ),
        .HRESETn  ( HRESETn  ),
        .HADDR    ( HADDR    ),
        .HREADY   ( HREADY   ),
        .hsel     ( hsel     ),
        .data_sel ( data_sel )
    );

    // ------------------------------------------------------------------------
    // Slaves
    // ------------------------------------------------------------------------
    ahb_ram_slave #(
        .RAM_ADDR_WIDTH  ( RAM_ADDR_WIDTH  ),
        .RAM_WAIT_STATES ( RAM_WAIT_STATES )
    ) u_ram (
        .HCLK      ( HCLK          ),
        .HRESETn   ( HRESETn       ),
        .hsel      ( hsel[SEL_RAM] ),
        .HADDR     ( HADDR         ),
        .HTRANS    ( HTRANS        ),
        .HSIZE     ( HSIZE         ),
        .HWRITE    ( HWRITE        ),
        .HWDATA    ( HWDATA        ),
        .HREADY    ( HREADY        ),
        .hreadyout ( ram_hreadyout ),
        .hrdata    ( ram_hrdata    ),
        .hresp     ( ram_hresp     )
    );

    ahb_gpio_slave u_gpio (
        .HCLK      ( HCLK           ),
        .HRESETn   ( HRESETn        ),
        .hsel      ( hsel[SEL_GPIO] ),
        .HADDR     ( HADDR          ),
        .HTRANS    ( HTRANS         ),
        .HWRITE    ( HWRITE         ),
        .HWDATA    ( HWDATA         ),
        .HREADY    ( HREADY         ),
        .switches  ( switches       ),
        .hreadyout ( gpio_hreadyout ),
        .hrdata    ( gpio_hrdata    ),
        .hresp     ( gpio_hresp     ),
        .leds      ( leds           ),
        .hex       ( hex            )
    );

    // Output side, including the default slave
    ahb_lite_response_mux u_response_mux (
        .HCLK           ( HCLK           ),
        .HRESETn        ( HRESETn        ),
        .hsel_def       ( hsel[SEL_DEF]  ),
        .HTRANS         ( HTRANS         ),
        .data_sel       ( data_sel       ),
        .ram_hreadyout  ( ram_hreadyout  ),
        .ram_hrdata     ( ram_hrdata     ),
        .ram_hresp      ( ram_hresp      ),
        .gpio_hreadyout ( gpio_hreadyout ),
        .gpio_hrdata    ( gpio_hrdata    ),
        .gpio_hresp     ( gpio_hresp     ),
        .HREADY         ( HREADY         ),
        .HRDATA         ( HRDATA         ),
        .HRESP          ( HRESP          )
    );

endmodule

// ==== src/ahb_lite_response_mux.sv ====
`timescale 1ns/1ps

module ahb_lite_response_mux (
    input  logic                  HCLK,
    input  logic                  HRESETn,
    input  logic                  hsel_def,
    input  ahb_lite_pkg::htrans_t HTRANS,
    input  ahb_lite_pkg::hsel_t   data_sel,
    input  logic                  ram_hreadyout,
    input  ahb_lite_pkg::hdata_t  ram_hrdata,
    input  logic                  ram_hresp,
    input  logic                  gpio_hreadyout,
    input  ahb_lite_pkg::hdata_t  gpio_hrdata,
    input  logic                  gpio_hresp,
    output logic                  HREADY,
    output ahb_lite_pkg::hdata_t  HRDATA,
    output logic                  HRESP
);

    import ahb_lite_pkg::*;

    typedef enum logic [1:0] {
        DEF_IDLE,
        DEF_ERR1,   // HREADY low, HRESP high
        DEF_ERR2    // HREADY high, HRESP high
    } def_state_t;

    def_state_t state;
    def_state_t state_next;
    logic       def_start;
    logic       def_ready;
    logic       def_resp;

    // ------------------------------------------------------------------------
    // Default slave
    // ------------------------------------------------------------------------
    assign def_start = hsel_def & HTRANS[1] & HREADY;

    always_comb begin
        state_next = state;
        case (state)
            DEF_IDLE: begin
                if (def_start) begin
                    state_next = DEF_ERR1;
                end
            end
            DEF_ERR1: state_next = DEF_ERR2;
            DEF_ERR2: state_next = def_start ? DEF_ERR1 : DEF_IDLE;  // Pipelined unmapped access
            default:  state_next = DEF_IDLE;
        endcase
    end

    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            state <= DEF_IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign def_ready = (state != DEF_ERR1);
    assign def_resp  = (state != DEF_IDLE);

    // ------------------------------------------------------------------------
    // Response select by data phase owner
    // ------------------------------------------------------------------------
    always_comb begin
        if (data_sel[SEL_RAM]) begin
            HREADY = ram_hreadyout;
            HRDATA = ram_hrdata;
            HRESP  = ram_hresp;
        end else if (data_sel[SEL_GPIO]) begin
            HREADY = gpio_hreadyout;
            HRDATA = gpio_hrdata;
            HRESP  = gpio_hresp;
        end else begin
            // SEL_DEF, or no owner yet after reset
            HREADY = def_ready;
            HRDATA = '0;
            HRESP  = def_resp;
        end
    end

endmodule

// ==== src/ahb_gpio_slave.sv ====
`timescale 1ns/1ps

module ahb_gpio_slave (
    input  logic                                  HCLK,
    input  logic                                  HRESETn,
    input  logic                                  hsel,
    input  ahb_lite_pkg::haddr_t                  HADDR,
    input  ahb_lite_pkg::htrans_t                 HTRANS,
    input  logic                                  HWRITE,
    input  ahb_lite_pkg::hdata_t                  HWDATA,
    input  logic                                  HREADY,
    input  logic [ahb_lite_pkg::N_SWITCHES-1:0]   switches,
    output logic                                  hreadyout,
    output ahb_lite_pkg::hdata_t                  hrdata,
    output logic                                  hresp,
    output logic [ahb_lite_pkg::N_LEDS-1:0]       leds,
    output logic [ahb_lite_pkg::HEX_WIDTH-1:0]    hex
);

    import ahb_lite_pkg::*;

    logic                  accept;
    logic                  active_q;
    logic [7:0]            ofs_q;
    logic                  write_q;
    logic [N_SWITCHES-1:0] sw_meta;
    logic [N_SWITCHES-1:0] sw_sync;
    logic [N_LEDS-1:0]     leds_q;
    logic [HEX_WIDTH-1:0]  hex_q;

    assign accept    = hsel & HTRANS[1] & HREADY;
    assign hreadyout = 1'b1;    // Zero wait states
    assign hresp     = 1'b0;

    // ------------------------------------------------------------------------
    // Address phase
    // ------------------------------------------------------------------------
    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            active_q <= 1'b0;
        end else if (HREADY) begin
            active_q <= accept;
        end
    end

    always_ff @(posedge HCLK) begin
        if (accept) begin
            ofs_q   <= HADDR[7:0];
            write_q <= HWRITE;
        end
    end

    // Switch inputs are asynchronous to HCLK
    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            sw_meta <= '0;
            sw_sync <= '0;
        end else begin
            sw_meta <= switches;
            sw_sync <= sw_meta;
        end
    end

    // ------------------------------------------------------------------------
    // Data phase
    // ------------------------------------------------------------------------
    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            leds_q <= '0;
            hex_q  <= '0;
        end else if (active_q && write_q && HREADY) begin
            case (ofs_q)
                GPIO_LED_OFS: leds_q <= HWDATA[N_LEDS-1:0];
                GPIO_HEX_OFS: hex_q  <= HWDATA[HEX_WIDTH-1:0];
                default: ;              // Switch and unmapped offsets ignored
            endcase
        end
    end

    always_comb begin
        hrdata = '0;
        if (active_q && !write_q) begin
            case (ofs_q)
                GPIO_SW_OFS:  hrdata = hdata_t'(sw_sync);
                GPIO_LED_OFS: hrdata = hdata_t'(leds_q);
                GPIO_HEX_OFS: hrdata = hdata_t'(hex_q);
                default:      hrdata = '0;
            endcase
        end
    end

    assign leds = leds_q;
    assign hex  = hex_q;

endmodule

// ==== src/ahb_ram_slave.sv ====
`timescale 1ns/1ps

module ahb_ram_slave #(
    parameter int RAM_ADDR_WIDTH  = 10,
    parameter int RAM_WAIT_STATES = 1
) (
    input  logic                  HCLK,
    input  logic                  HRESETn,
    input  logic                  hsel,
    input  ahb_lite_pkg::haddr_t  HADDR,
    input  ahb_lite_pkg::htrans_t HTRANS,
    input  ahb_lite_pkg::hsize_t  HSIZE,
    input  logic                  HWRITE,
    input  ahb_lite_pkg::hdata_t  HWDATA,
    input  logic                  HREADY,
    output logic                  hreadyout,
    output ahb_lite_pkg::hdata_t  hrdata,
    output logic                  hresp
);

    import ahb_lite_pkg::*;

    hdata_t mem [2**RAM_ADDR_WIDTH];

    logic                      accept;
    logic                      active_q;    // Data phase in progress
    logic [1:0]                wait_cnt;
    logic                      last_cycle;
    logic [RAM_ADDR_WIDTH-1:0] word_q;
    logic [1:0]                lane_q;
    hsize_t                    size_q;
    logic                      write_q;
    logic [3:0]                byte_en;

    assign accept = hsel & HTRANS[1] & HREADY;

    // ------------------------------------------------------------------------
    // Data phase control
    // ------------------------------------------------------------------------
    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            active_q <= 1'b0;
            wait_cnt <= '0;
        end else if (accept) begin
            active_q <= 1'b1;
            wait_cnt <= 2'(RAM_WAIT_STATES);
        end else if (wait_cnt != '0) begin
            wait_cnt <= wait_cnt - 2'd1;
        end else if (HREADY) begin
            active_q <= 1'b0;
        end
    end

    // Address phase capture
    always_ff @(posedge HCLK) begin
        if (accept) begin
            word_q  <= HADDR[RAM_ADDR_WIDTH+1:2];
            lane_q  <= HADDR[1:0];
            size_q  <= HSIZE;
            write_q <= HWRITE;
        end
    end

    assign last_cycle = active_q && (wait_cnt == '0);
    assign hreadyout  = !(active_q && (wait_cnt != '0));
    assign hresp      = 1'b0;   // Always OKAY

    // ------------------------------------------------------------------------
    // Byte lanes, little-endian
    // ------------------------------------------------------------------------
    always_comb begin
        case (size_q)
            SIZE_BYTE: byte_en = 4'b0001 << lane_q;
            SIZE_HALF: byte_en = lane_q[1] ? 4'b1100 : 4'b0011;
            SIZE_WORD: byte_en = 4'b1111;
            default:   byte_en = 4'b0000;   // Wider than the bus
        endcase
    end

    always_ff @(posedge HCLK) begin
        if (last_cycle && write_q) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) begin
                    mem[word_q][8*i +: 8] <= HWDATA[8*i +: 8];
                end
            end
        end
    end

    // Whole word on reads, the master picks its lanes
    assign hrdata = (active_q && !write_q) ? mem[word_q] : '0;

endmodule

// ==== src/ahb_lite_decoder.sv ====
`timescale 1ns/1ps

module ahb_lite_decoder (
    input  logic                 HCLK,
    input  logic                 HRESETn,
    input  ahb_lite_pkg::haddr_t HADDR,
    input  logic                 HREADY,
    output ahb_lite_pkg::hsel_t  hsel,
    output ahb_lite_pkg::hsel_t  data_sel
);

    import ahb_lite_pkg::*;

    // ------------------------------------------------------------------------
    // Address phase decode
    // ------------------------------------------------------------------------
    logic ram_hit;
    logic gpio_hit;

    assign ram_hit  = (HADDR[31:16] == RAM_MATCH);
    assign gpio_hit = (HADDR[31:12] == GPIO_MATCH);

    always_comb begin
        hsel = '0;
        if (ram_hit) begin
            hsel[SEL_RAM] = 1'b1;
        end else if (gpio_hit) begin
            hsel[SEL_GPIO] = 1'b1;
        end else begin
            hsel[SEL_DEF] = 1'b1;   // Nothing mapped here
        end
    end

    // ------------------------------------------------------------------------
    // Data phase owner
    // ------------------------------------------------------------------------
    // Follows the address phase that just completed, frozen while stalled
    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            data_sel <= '0;
        end else if (HREADY) begin
            data_sel <= hsel;
        end
    end

endmodule

// ==== src/ahb_lite_pkg.sv ====
package ahb_lite_pkg;

    // ------------------------------------------------------------------------
    // Bus field types
    // ------------------------------------------------------------------------
    typedef logic [31:0] haddr_t;
    typedef logic [31:0] hdata_t;
    typedef logic [1:0]  htrans_t;   // Bit 1 set means an active transfer
    typedef logic [2:0]  hsize_t;
    typedef logic [2:0]  hsel_t;     // One-hot, indexed by SEL_*

    localparam htrans_t HTRANS_IDLE   = 2'b00;
    localparam htrans_t HTRANS_BUSY   = 2'b01;
    localparam htrans_t HTRANS_NONSEQ = 2'b10;
    localparam htrans_t HTRANS_SEQ    = 2'b11;

    localparam hsize_t SIZE_BYTE = 3'b000;
    localparam hsize_t SIZE_HALF = 3'b001;
    localparam hsize_t SIZE_WORD = 3'b010;

    // Slave select indices
    localparam int SEL_RAM  = 0;
    localparam int SEL_GPIO = 1;
    localparam int SEL_DEF  = 2;   // Unmapped, answered by the default slave

    // ------------------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------------------
    localparam logic [15:0] RAM_MATCH  = 16'h0000;    // HADDR[31:16], 0x0000_0000
    localparam logic [19:0] GPIO_MATCH = 20'h1F800;   // HADDR[31:12], 0x1F80_0000

    // GPIO register offsets
    localparam logic [7:0] GPIO_SW_OFS  = 8'h00;
    localparam logic [7:0] GPIO_LED_OFS = 8'h04;
    localparam logic [7:0] GPIO_HEX_OFS = 8'h08;

    localparam int N_SWITCHES = 16;
    localparam int N_LEDS     = 16;
    localparam int HEX_WIDTH  = 32;

endpackage
